/* Bender.yml */
package:
  name: alu_pipe

sources:
  - verilog/pipe_pkg.sv
  - verilog/pipe_ctrl.sv
  - verilog/decode_stage.sv
  - verilog/exec_stage.sv
  - verilog/pipe_cmd_fsm.sv
  - verilog/pipe_counters.sv
  - verilog/apb_regs.sv
  - verilog/alu_pipe_top.sv
  - target: simulation
    files:
      - tests/alu_pipe_tb.sv

/* files.f */
verilog/pipe_pkg.sv
verilog/pipe_ctrl.sv
verilog/decode_stage.sv
verilog/exec_stage.sv
verilog/pipe_cmd_fsm.sv
verilog/pipe_counters.sv
verilog/apb_regs.sv
verilog/alu_pipe_top.sv
tests/alu_pipe_tb.sv

/* tests/alu_pipe_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module alu_pipe_tb;
  import pipe_pkg::*;

  localparam int APB_TIMEOUT   = 10;
  localparam int QUEUE_TIMEOUT = 500;

  logic      clk;
  logic      rst_n;
  logic      psel_i;
  logic      penable_i;
  logic      pwrite_i;
  apb_addr_t paddr_i;
  apb_data_t pwdata_i;
  apb_data_t prdata_o;
  logic      pready_o;
  logic      pslverr_o;
  logic      in_valid_i;
  req_t      in_req_i;
  logic      in_ready_o;
  logic      out_valid_o;
  rsp_t      out_rsp_o;
  logic      out_ready_i;

  // Reference model state
  rsp_t exp_q[$];
  rsp_t front;
  int   exp_done;
  int   exp_drop;

  // Stream driver controls
  logic      stream_on;
  int        ready_pct;
  logic      in_taken;
  logic      apb_err;
  apb_data_t unmapped_rdata;

  alu_pipe_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .in_valid_i (in_valid_i),
    .in_req_i   (in_req_i),
    .in_ready_o (in_ready_o),
    .out_valid_o(out_valid_o),
    .out_rsp_o  (out_rsp_o),
    .out_ready_i(out_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("error: %s is 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  function automatic req_t random_req();
    req_t req;
    req.op  = op_e'($urandom % 6);
    req.a   = word_t'($urandom);
    req.b   = word_t'($urandom);
    req.tag = tag_t'($urandom);
    return req;
  endfunction

  // Arithmetic as the opcodes define it, product cut to 16 bits
  function automatic rsp_t model_rsp(input req_t req);
    rsp_t        rsp;
    logic [31:0] product;
    rsp.tag = req.tag;
    case (req.op)
      OP_ADD: rsp.result = req.a + req.b;
      OP_SUB: rsp.result = req.a - req.b;
      OP_AND: rsp.result = req.a & req.b;
      OP_XOR: rsp.result = req.a ^ req.b;
      default: begin
        product    = req.a * req.b;
        rsp.result = product[15:0];
      end
    endcase
    return rsp;
  endfunction

  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    int waited;
    @(posedge clk);
    #10;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk);
    #10;
    penable_i = 1'b1;
    waited    = 0;
    @(negedge clk);
    while (!pready_o) begin
      waited++;
      if (waited > APB_TIMEOUT) begin
        report_failure("APB access timed out waiting for pready_o");
      end
      @(negedge clk);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk);
    #10;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  task automatic write_ctrl(input apb_data_t value);
    logic err;
    apb_write(REG_CTRL, value, err);
    check_value("CTRL write pslverr_o", err, 0);
  endtask

  task automatic expect_reg(input apb_addr_t addr, input apb_data_t value, input string name);
    apb_data_t rdata;
    logic      err;
    apb_read(addr, rdata, err);
    check_value({name, " pslverr_o"}, err, 0);
    check_value(name, rdata, value);
  endtask

  // Takes effect from the driver's next update
  task automatic set_stream(input logic on, input int pct);
    @(posedge clk);
    stream_on = on;
    ready_pct = pct;
  endtask

  // Zero target also waits for the source to go quiet
  task automatic wait_queue(input int target, input string what);
    int waited;
    waited = 0;
    while (exp_q.size() != target || (target == 0 && in_valid_i)) begin
      @(posedge clk);
      waited++;
      if (waited > QUEUE_TIMEOUT) begin
        report_failure({"Timed out waiting for ", what});
      end
    end
  endtask

  // Request is held until the DUT takes it
  always begin
    @(posedge clk);
    #10;
    if (!in_valid_i || in_taken) begin
      in_taken = 1'b0;
      if (stream_on && ($urandom % 100) < 70) begin
        in_valid_i = 1'b1;
        in_req_i   = random_req();
      end else begin
        in_valid_i = 1'b0;
      end
    end
    out_ready_i = (($urandom % 100) < ready_pct);
  end

  // Sampled mid-cycle, so these are the values at the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          report_failure($sformatf("Output with tag 0x%h arrived while no result was pending",
                                   out_rsp_o.tag));
        end else begin
          front = exp_q.pop_front();
          check_value("out_rsp_o.result", out_rsp_o.result, front.result);
          check_value("out_rsp_o.tag", out_rsp_o.tag, front.tag);
        end
      end
      if (in_valid_i && in_ready_o) begin
        in_taken = 1'b1;
        if (in_req_i.op == OP_NOP) begin
          exp_drop++;
        end else begin
          exp_q.push_back(model_rsp(in_req_i));
          exp_done++;
        end
      end
    end
  end

  initial begin
    void'($urandom(5537));
    rst_n       = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    in_valid_i  = 1'b0;
    in_req_i    = '0;
    out_ready_i = 1'b0;
    stream_on   = 1'b0;
    ready_pct   = 0;
    in_taken    = 1'b0;
    exp_done    = 0;
    exp_drop    = 0;
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;

    // Idle after reset
    @(negedge clk);
    check_value("in_ready_o", in_ready_o, 0);
    check_value("out_valid_o", out_valid_o, 0);
    expect_reg(REG_STATUS, apb_data_t'(ST_IDLE), "STATUS");
    expect_reg(REG_DONE, 0, "DONE");
    expect_reg(REG_DROP, 0, "DROP");

    // Random traffic with random backpressure
    write_ctrl(32'h1);
    set_stream(1'b1, 70);
    repeat (200) @(posedge clk);
    set_stream(1'b0, 100);
    wait_queue(0, "the pipeline to drain after random traffic");
    expect_reg(REG_DONE, exp_done, "DONE");
    expect_reg(REG_DROP, exp_drop, "DROP");

    // Pause in the middle of traffic
    set_stream(1'b1, 60);
    repeat (40) @(posedge clk);
    write_ctrl(32'h3);
    @(posedge clk);
    repeat (8) begin
      @(negedge clk);
      check_value("in_ready_o", in_ready_o, 0);
      check_value("out_valid_o", out_valid_o, 0);
    end
    write_ctrl(32'h1);
    repeat (40) @(posedge clk);
    set_stream(1'b0, 100);
    wait_queue(0, "the pipeline to drain after pause");
    expect_reg(REG_DONE, exp_done, "DONE");
    expect_reg(REG_DROP, exp_drop, "DROP");

    // Both stages full with the output blocked, then flush
    set_stream(1'b1, 0);
    wait_queue(2, "two requests in flight");
    set_stream(1'b0, 0);
    write_ctrl(32'h4);
    repeat (3) @(posedge clk);
    exp_done = exp_done - exp_q.size();
    exp_q.delete();
    expect_reg(REG_STATUS, apb_data_t'(ST_IDLE), "STATUS");
    set_stream(1'b0, 100);
    repeat (6) @(posedge clk);
    write_ctrl(32'h1);
    set_stream(1'b1, 70);
    repeat (100) @(posedge clk);
    set_stream(1'b0, 100);
    wait_queue(0, "the pipeline to drain after flush");
    expect_reg(REG_DONE, exp_done, "DONE");
    expect_reg(REG_DROP, exp_drop, "DROP");

    // Counter clear keeps run set
    write_ctrl(32'h9);
    exp_done = 0;
    exp_drop = 0;
    expect_reg(REG_DONE, 0, "DONE");
    expect_reg(REG_DROP, 0, "DROP");

    // Unmapped addresses
    apb_write(4'h2, 32'h6, apb_err);
    check_value("unmapped write pslverr_o", apb_err, 1);
    apb_read(4'h6, unmapped_rdata, apb_err);
    check_value("unmapped read pslverr_o", apb_err, 1);
    expect_reg(REG_CTRL, 32'h1, "CTRL");

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/alu_pipe_top.sv */
`default_nettype none
`timescale 1ns/1ps

module alu_pipe_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  pipe_pkg::apb_addr_t paddr_i,
  input  pipe_pkg::apb_data_t pwdata_i,
  output pipe_pkg::apb_data_t prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  input  logic                in_valid_i,
  input  pipe_pkg::req_t      in_req_i,
  output logic                in_ready_o,
  output logic                out_valid_o,
  output pipe_pkg::rsp_t      out_rsp_o,
  input  logic                out_ready_i
);
  import pipe_pkg::*;

  // Decode to exec
  logic   dec_valid;
  uop_t   dec_uop;
  logic   exe_ready;

  // Control path
  cmd_t   cmd;
  state_e state;
  logic   stall_dec;
  logic   stall_exe;
  logic   flush;
  logic   done;
  logic   drop;
  count_t done_cnt;
  count_t drop_cnt;

  decode_stage u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid_i(in_valid_i),
    .in_req_i  (in_req_i),
    .in_ready_o(in_ready_o),
    .stall_i   (stall_dec),
    .flush_i   (flush),
    .ready_i   (exe_ready),
    .valid_o   (dec_valid),
    .uop_o     (dec_uop),
    .drop_o    (drop)
  );

  exec_stage u_exec (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (dec_valid),
    .uop_i      (dec_uop),
    .ready_o    (exe_ready),
    .stall_i    (stall_exe),
    .flush_i    (flush),
    .out_ready_i(out_ready_i),
    .out_valid_o(out_valid_o),
    .out_rsp_o  (out_rsp_o),
    .done_o     (done)
  );

  pipe_cmd_fsm u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_i      (cmd),
    .stall_dec_o(stall_dec),
    .stall_exe_o(stall_exe),
    .flush_o    (flush),
    .state_o    (state)
  );

  pipe_counters u_counters (
    .clk       (clk),
    .rst_n     (rst_n),
    .done_i    (done),
    .drop_i    (drop),
    .clear_i   (cmd.clear_pulse),
    .done_cnt_o(done_cnt),
    .drop_cnt_o(drop_cnt)
  );

  apb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .state_i   (state),
    .done_cnt_i(done_cnt),
    .drop_cnt_i(drop_cnt),
    .cmd_o     (cmd)
  );

endmodule

`default_nettype wire

/* verilog/apb_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module apb_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  pipe_pkg::apb_addr_t paddr_i,
  input  pipe_pkg::apb_data_t pwdata_i,
  output pipe_pkg::apb_data_t prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  input  pipe_pkg::state_e    state_i,
  input  pipe_pkg::count_t    done_cnt_i,
  input  pipe_pkg::count_t    drop_cnt_i,
  output pipe_pkg::cmd_t      cmd_o
);
  import pipe_pkg::*;

  logic access;
  logic addr_hit;
  logic wr_ctrl;
  logic run_q;
  logic pause_q;
  logic flush_q;
  logic clear_q;

  // Zero wait states, every access ends in its first ACCESS cycle
  assign access   = psel_i && penable_i;
  assign wr_ctrl  = access && pwrite_i && (paddr_i == REG_CTRL);
  assign pready_o = 1'b1;

  always_comb begin
    addr_hit = 1'b1;
    case (paddr_i)
      REG_CTRL:   prdata_o = apb_data_t'({pause_q, run_q});
      REG_STATUS: prdata_o = apb_data_t'(state_i);
      REG_DONE:   prdata_o = apb_data_t'(done_cnt_i);
      REG_DROP:   prdata_o = apb_data_t'(drop_cnt_i);
      default: begin
        prdata_o = '0;
        addr_hit = 1'b0;
      end
    endcase
  end

  assign pslverr_o = access && !addr_hit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_q   <= 1'b0;
      pause_q <= 1'b0;
      flush_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      // Flush and clear are one-cycle strobes
      flush_q <= wr_ctrl && pwdata_i[2];
      clear_q <= wr_ctrl && pwdata_i[3];
      if (wr_ctrl) begin
        run_q   <= pwdata_i[0];
        pause_q <= pwdata_i[1];
      end
    end
  end

  always_comb begin
    cmd_o.run         = run_q;
    cmd_o.pause       = pause_q;
    cmd_o.flush_pulse = flush_q;
    cmd_o.clear_pulse = clear_q;
  end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid_i,
  input  pipe_pkg::req_t in_req_i,
  output logic           in_ready_o,
  input  logic           stall_i,
  input  logic           flush_i,
  input  logic           ready_i,
  output logic           valid_o,
  output pipe_pkg::uop_t uop_o,
  output logic           drop_o
);
  import pipe_pkg::*;

  logic is_nop;
  logic advance;
  logic held_valid;
  uop_t uop_d;
  uop_t uop_q;

  assign is_nop = in_valid_i && (in_req_i.op == OP_NOP);

  pipe_ctrl #(
    .REG(STAGE_REG)
  ) u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (in_valid_i),
    .ready_i  (ready_i),
    .stall_i  (stall_i),
    .flush_i  (flush_i),
    .bubble_i (is_nop),
    .valid_o  (held_valid),
    .ready_o  (in_ready_o),
    .advance_o(advance),
    .flush_o  (),
    .bubble_o (drop_o)
  );

  always_comb begin
    uop_d.kind     = UOP_ADD;
    uop_d.a        = in_req_i.a;
    uop_d.b        = in_req_i.b;
    uop_d.carry_in = 1'b0;
    uop_d.tag      = in_req_i.tag;
    case (in_req_i.op)
      // a - b is a + ~b + 1
      OP_SUB: begin
        uop_d.b        = ~in_req_i.b;
        uop_d.carry_in = 1'b1;
      end
      OP_AND:  uop_d.kind = UOP_AND;
      OP_XOR:  uop_d.kind = UOP_XOR;
      OP_MUL:  uop_d.kind = UOP_MUL;
      default: uop_d.kind = UOP_ADD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      uop_q <= uop_d;
    end
  end

  // A stalled decode keeps its micro-op and offers nothing to exec
  assign valid_o = held_valid && !stall_i;
  assign uop_o   = uop_q;

endmodule

`default_nettype wire

/* verilog/exec_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module exec_stage (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           valid_i,
  input  pipe_pkg::uop_t uop_i,
  output logic           ready_o,
  input  logic           stall_i,
  input  logic           flush_i,
  input  logic           out_ready_i,
  output logic           out_valid_o,
  output pipe_pkg::rsp_t out_rsp_o,
  output logic           done_o
);
  import pipe_pkg::*;

  logic  advance;
  logic  held_valid;
  word_t result_d;
  rsp_t  rsp_q;

  pipe_ctrl #(
    .REG(STAGE_REG)
  ) u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (valid_i),
    .ready_i  (out_ready_i),
    .stall_i  (stall_i),
    .flush_i  (flush_i),
    .bubble_i (1'b0),
    .valid_o  (held_valid),
    .ready_o  (ready_o),
    .advance_o(advance),
    .flush_o  (),
    .bubble_o ()
  );

  always_comb begin
    case (uop_i.kind)
      UOP_ADD: result_d = uop_i.a + uop_i.b + word_t'(uop_i.carry_in);
      UOP_AND: result_d = uop_i.a & uop_i.b;
      UOP_XOR: result_d = uop_i.a ^ uop_i.b;
      // Only the low half of the product is kept
      UOP_MUL: result_d = uop_i.a * uop_i.b;
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      rsp_q.result <= result_d;
      rsp_q.tag    <= uop_i.tag;
    end
  end

  // No transfer while paused or while the pipe is being flushed
  assign out_valid_o = held_valid && !stall_i && !flush_i;
  assign out_rsp_o   = rsp_q;
  assign done_o      = out_valid_o && out_ready_i;

  // Result must not change under backpressure
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> $stable(out_rsp_o));

endmodule

`default_nettype wire

/* verilog/pipe_cmd_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module pipe_cmd_fsm (
  input  logic             clk,
  input  logic             rst_n,
  input  pipe_pkg::cmd_t   cmd_i,
  output logic             stall_dec_o,
  output logic             stall_exe_o,
  output logic             flush_o,
  output pipe_pkg::state_e state_o
);
  import pipe_pkg::*;

  state_e state_q;
  state_e state_d;

  always_comb begin
    state_d = state_q;
    if (state_q == ST_FLUSH) begin
      // Flush is a single cycle
      state_d = ST_IDLE;
    end else if (cmd_i.flush_pulse) begin
      state_d = ST_FLUSH;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_i.run) begin
            state_d = ST_RUN;
          end
        end
        ST_RUN: begin
          if (!cmd_i.run) begin
            state_d = ST_IDLE;
          end else if (cmd_i.pause) begin
            state_d = ST_PAUSE;
          end
        end
        ST_PAUSE: begin
          if (!cmd_i.run) begin
            state_d = ST_IDLE;
          end else if (!cmd_i.pause) begin
            state_d = ST_RUN;
          end
        end
        default: state_d = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Idle still lets exec drain its last result
  assign stall_dec_o = (state_q != ST_RUN);
  assign stall_exe_o = (state_q == ST_PAUSE);
  assign flush_o     = (state_q == ST_FLUSH);
  assign state_o     = state_q;

  assert property (@(posedge clk) disable iff (!rst_n)
    state_q == ST_FLUSH |=> state_q != ST_FLUSH);

endmodule

`default_nettype wire

/* verilog/pipe_counters.sv */
`default_nettype none
`timescale 1ns/1ps

module pipe_counters (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             done_i,
  input  logic             drop_i,
  input  logic             clear_i,
  output pipe_pkg::count_t done_cnt_o,
  output pipe_pkg::count_t drop_cnt_o
);
  import pipe_pkg::*;

  count_t done_q;
  count_t drop_q;

  // Stops at all ones instead of wrapping
  function automatic count_t sat_inc(input count_t value, input logic en);
    if (en && (value != '1)) begin
      return value + count_t'(1);
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      done_q <= '0;
      drop_q <= '0;
    end else begin
      done_q <= sat_inc(done_q, done_i);
      drop_q <= sat_inc(drop_q, drop_i);
    end
  end

  assign done_cnt_o = done_q;
  assign drop_cnt_o = drop_q;

endmodule

`default_nettype wire

/* verilog/pipe_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module pipe_ctrl #(
  parameter int REG = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  logic ready_i,
  input  logic stall_i,
  input  logic flush_i,
  input  logic bubble_i,
  output logic valid_o,
  output logic ready_o,
  output logic advance_o,
  output logic flush_o,
  output logic bubble_o
);

  if (REG != 0) begin : g_reg
    logic can_accept;
    logic valid_q;

    // Stage can take a new item unless stalled or its own output is stuck
    assign can_accept = !stall_i && !(valid_q && !ready_i);

    // Priority is flush, hold, bubble, advance
    assign flush_o   = flush_i;
    assign bubble_o  = !flush_i && bubble_i && can_accept;
    assign advance_o = !flush_i && !bubble_i && valid_i && can_accept;
    assign ready_o   = can_accept;
    assign valid_o   = valid_q;

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= 1'b0;
      end else if (flush_o || bubble_o) begin
        valid_q <= 1'b0;
      end else if (can_accept) begin
        valid_q <= valid_i;
      end
    end
  end else begin : g_pass
    // No register, so the stage always moves its input along
    assign valid_o   = valid_i;
    assign ready_o   = ready_i;
    assign advance_o = 1'b1;
    assign flush_o   = 1'b0;
    assign bubble_o  = 1'b0;
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(flush_o && advance_o));
  assert property (@(posedge clk) disable iff (!rst_n) bubble_o |-> !advance_o);

endmodule

`default_nettype wire

/* verilog/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  // Widths
  localparam int WORD_W  = 16;
  localparam int TAG_W   = 4;
  localparam int COUNT_W = 16;
  localparam int APB_AW  = 4;
  localparam int APB_DW  = 32;

  // Both stage controllers keep a registered valid
  localparam int STAGE_REG = 1;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [APB_AW-1:0]  apb_addr_t;
  typedef logic [APB_DW-1:0]  apb_data_t;

  typedef enum logic [2:0] {
    OP_NOP = 3'd0,
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    OP_AND = 3'd3,
    OP_XOR = 3'd4,
    OP_MUL = 3'd5
  } op_e;

  typedef enum logic [1:0] {
    UOP_ADD = 2'd0,
    UOP_AND = 2'd1,
    UOP_XOR = 2'd2,
    UOP_MUL = 2'd3
  } uop_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_PAUSE = 2'd2,
    ST_FLUSH = 2'd3
  } state_e;

  typedef struct packed {
    op_e   op;
    word_t a;
    word_t b;
    tag_t  tag;
  } req_t;

  // Subtract arrives here as an add with b inverted and carry_in set
  typedef struct packed {
    uop_e  kind;
    word_t a;
    word_t b;
    logic  carry_in;
    tag_t  tag;
  } uop_t;

  typedef struct packed {
    word_t result;
    tag_t  tag;
  } rsp_t;

  typedef struct packed {
    logic run;
    logic pause;
    logic flush_pulse;
    logic clear_pulse;
  } cmd_t;

  // Register map
  localparam apb_addr_t REG_CTRL   = 4'h0;
  localparam apb_addr_t REG_STATUS = 4'h4;
  localparam apb_addr_t REG_DONE   = 4'h8;
  localparam apb_addr_t REG_DROP   = 4'hC;

endpackage

`default_nettype wire
